/* vlog.f */
hw/dbg_pkg.sv
hw/cmd_if.sv
hw/spi_byte_link.sv
hw/cmd_parser.sv
hw/host_ram.sv
hw/breakpoint_unit.sv
hw/dbg_top.sv
sim/tb_dbg_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_dbg_top -o tb_dbg_top
./obj_dir/tb_dbg_top > sim.log 2>&1 || true
cat sim.log
if grep -q "TEST FAIL" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

/* sim/tb_dbg_top.sv */
module tb_dbg_top;
  import dbg_pkg::*;

  localparam int NUM_BP    = 8;
  localparam int RAM_W     = 10;
  localparam int SPI_BYTES = 188;  // all bytes sent by the tests below
  localparam int N_POKES   = 20;

  logic        clk;
  logic        rst;
  logic        spi_cs_n;
  logic        spi_sck;
  logic        spi_mosi;
  addr_t       bus_addr;
  logic        bus_rd;
  logic        spi_miso;
  logic        bp_hit;
  logic [2:0]  bp_index;

  logic [31:0] lfsr;                    // fibonacci lfsr state
  int          errors;
  int          checks;
  byte_t       ram_model [2**RAM_W];    // last poke per truncated address
  addr_t       poke_addr [N_POKES];

  dbg_top #(.NUM_BREAKPOINTS(NUM_BP), .RAM_ADDR_W(RAM_W)) i_dut (
    .clk      (clk),
    .rst      (rst),
    .spi_cs_n (spi_cs_n),
    .spi_sck  (spi_sck),
    .spi_mosi (spi_mosi),
    .bus_addr (bus_addr),
    .bus_rd   (bus_rd),
    .spi_miso (spi_miso),
    .bp_hit   (bp_hit),
    .bp_index (bp_index)
  );

  always #4 clk = ~clk;

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_step(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  task automatic wait_clk(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("FAILED %s expected %h got %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      $display("%s", what);
      errors++;
    end
  endtask

  // one spi byte, msb first, sck idles low
  // miso read late in the low phase, after the dut has shifted on the fall
  task automatic spi_xfer(input byte_t tx, output byte_t rx);
    for (int i = 7; i >= 0; i--) begin
      @(posedge clk);
      spi_mosi <= tx[i];
      wait_clk(5);       // mosi setup
      spi_sck <= 1'b1;
      wait_clk(10);
      spi_sck <= 1'b0;
      wait_clk(4);
      @(negedge clk);
      rx[i] = spi_miso;
    end
  endtask

  // whole message framed by cs, optional reply byte at the end
  task automatic message(input int n, input byte_t b0, input byte_t b1, input byte_t b2,
                         input byte_t b3, input logic read_reply, output byte_t reply);
    byte_t tx [4];
    byte_t unused;
    tx[0] = b0;
    tx[1] = b1;
    tx[2] = b2;
    tx[3] = b3;
    reply = '0;
    @(posedge clk);
    spi_cs_n <= 1'b0;
    wait_clk(8);
    for (int k = 0; k < n; k++) begin
      spi_xfer(tx[k], unused);
    end
    if (read_reply) begin
      spi_xfer(8'hff, reply); // mosi ignored here
    end
    wait_clk(8);
    spi_cs_n <= 1'b1;
    wait_clk(8);
  endtask

  // read strobe held for hold clk, hits counted over hold + 6 clk
  task automatic bus_read(input addr_t addr, input int hold, output int pulses,
                          output int first_at, output int idx);
    pulses   = 0;
    first_at = -1;
    idx      = -1;
    @(posedge clk);
    bus_addr <= addr;
    bus_rd   <= 1'b1;
    for (int c = 1; c <= hold + 6; c++) begin
      @(negedge clk);
      if (bp_hit) begin
        pulses++;
        if (first_at < 0) begin
          first_at = c;
          idx      = int'(bp_index);
        end
      end
      @(posedge clk);
      if (c == hold) bus_rd <= 1'b0;
    end
  endtask

  initial begin
    repeat (SPI_BYTES * 200 + 2000) @(posedge clk);
    $display("watchdog expired before the tests finished");
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    byte_t r;
    byte_t d;
    addr_t a_bp;
    addr_t b_bp;
    int    pulses;
    int    first_at;
    int    idx;
    clk      = 1'b0;
    rst      = 1'b1;
    spi_cs_n = 1'b1;
    spi_sck  = 1'b0;
    spi_mosi = 1'b0;
    bus_addr = '0;
    bus_rd   = 1'b0;
    lfsr     = 32'h3da0;
    errors   = 0;
    checks   = 0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    wait_clk(4);

    // cookie and version
    message(1, get_cookie, 8'h00, 8'h00, 8'h00, 1'b1, r);
    check_eq("spi_miso cookie", 32'h af, 32'(r));
    message(1, get_version, 8'h00, 8'h00, 8'h00, 1'b1, r);
    check_eq("spi_miso version", 32'h03, 32'(r)); // major 0, minor 3

    // poke then peek, address truncated to RAM_W bits
    for (int i = 0; i < N_POKES; i++) begin
      poke_addr[i] = addr_t'(take_bits(16));
      d            = byte_t'(take_bits(8));
      ram_model[poke_addr[i][RAM_W-1:0]] = d;
      message(4, bram_poke, poke_addr[i][7:0], poke_addr[i][15:8], d, 1'b0, r);
    end
    for (int i = 0; i < N_POKES; i++) begin
      message(3, bram_peek, poke_addr[i][7:0], poke_addr[i][15:8], 8'h00, 1'b1, r);
      check_eq("spi_miso peek", 32'(ram_model[poke_addr[i][RAM_W-1:0]]), 32'(r));
    end

    // slot 5, enabled, hit and miss
    a_bp = addr_t'(take_bits(16));
    message(4, set_breakpoint, 8'd5, a_bp[7:0], a_bp[15:8], 1'b0, r);
    message(1, enable_breakpoints, 8'h00, 8'h00, 8'h00, 1'b0, r);
    bus_read(a_bp, 2, pulses, first_at, idx);
    check_eq("bp_hit pulses", 32'd1, 32'(pulses));
    check_true(first_at >= 1 && first_at <= 4, "breakpoint hit came later than 4 clk");
    check_eq("bp_index", 32'd5, 32'(idx));
    bus_read(a_bp ^ 16'h0001, 2, pulses, first_at, idx);
    check_eq("bp_hit pulses on miss", 32'd0, 32'(pulses));

    // same address in slots 2 and 6, lowest slot first
    b_bp = a_bp ^ 16'h8000;
    message(4, set_breakpoint, 8'd2, b_bp[7:0], b_bp[15:8], 1'b0, r);
    message(4, set_breakpoint, 8'd6, b_bp[7:0], b_bp[15:8], 1'b0, r);
    bus_read(b_bp, 2, pulses, first_at, idx);
    check_eq("bp_index", 32'd2, 32'(idx));
    message(2, clear_breakpoint, 8'd2, 8'h00, 8'h00, 1'b0, r);
    bus_read(b_bp, 8, pulses, first_at, idx);   // long strobe, single pulse
    check_eq("bp_index", 32'd6, 32'(idx));
    check_eq("bp_hit pulses held rd", 32'd1, 32'(pulses));
    message(1, disable_breakpoints, 8'h00, 8'h00, 8'h00, 1'b0, r);
    bus_read(b_bp, 2, pulses, first_at, idx);
    check_eq("bp_hit pulses disabled", 32'd0, 32'(pulses));

    // peek cut off after one parameter
    message(2, bram_peek, poke_addr[0][7:0], 8'h00, 8'h00, 1'b0, r);
    message(1, get_cookie, 8'h00, 8'h00, 8'h00, 1'b1, r);
    check_eq("spi_miso cookie after abort", 32'haf, 32'(r));
    message(3, bram_peek, poke_addr[0][7:0], poke_addr[0][15:8], 8'h00, 1'b1, r);
    check_eq("spi_miso peek after abort", 32'(ram_model[poke_addr[0][RAM_W-1:0]]), 32'(r));

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* hw/dbg_top.sv */
module dbg_top #(
  parameter int NUM_BREAKPOINTS = 8,
  parameter int RAM_ADDR_W      = 10
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               spi_cs_n,
  input  logic                               spi_sck,
  input  logic                               spi_mosi,
  input  dbg_pkg::addr_t                     bus_addr,
  input  logic                               bus_rd,   // active high read strobe
  output logic                               spi_miso,
  output logic                               bp_hit,
  output logic [$clog2(NUM_BREAKPOINTS)-1:0] bp_index
);
  import dbg_pkg::*;

  byte_t rx_byte;
  logic  rx_strobe;
  logic  cs_active;
  logic  accept_rx;
  logic  reply_busy;
  byte_t reply_byte;
  logic  reply_bits_load;
  byte_t rd_data;         // peek result
  logic  rd_valid;

  cmd_if cmd_bus ();

  spi_byte_link i_link (
    .clk             (clk),
    .rst             (rst),
    .spi_cs_n        (spi_cs_n),
    .spi_sck         (spi_sck),
    .spi_mosi        (spi_mosi),
    .reply_byte      (reply_byte),
    .reply_bits_load (reply_bits_load),
    .accept_rx       (accept_rx),
    .spi_miso        (spi_miso),
    .rx_byte         (rx_byte),
    .rx_strobe       (rx_strobe),
    .cs_active       (cs_active),
    .reply_busy      (reply_busy)
  );

  cmd_parser i_parser (
    .clk             (clk),
    .rst             (rst),
    .rx_byte         (rx_byte),
    .rx_strobe       (rx_strobe),
    .cs_active       (cs_active),
    .reply_busy      (reply_busy),
    .rd_data         (rd_data),
    .rd_valid        (rd_valid),
    .accept_rx       (accept_rx),
    .reply_byte      (reply_byte),
    .reply_bits_load (reply_bits_load),
    .cmd_bus         (cmd_bus.parser)
  );

  host_ram #(.RAM_ADDR_W(RAM_ADDR_W)) i_ram (
    .clk      (clk),
    .rst      (rst),
    .cmd_bus  (cmd_bus.sink),
    .rd_data  (rd_data),
    .rd_valid (rd_valid)
  );

  breakpoint_unit #(.NUM_BREAKPOINTS(NUM_BREAKPOINTS)) i_bp (
    .clk      (clk),
    .rst      (rst),
    .cmd_bus  (cmd_bus.sink),
    .bus_addr (bus_addr),
    .bus_rd   (bus_rd),
    .bp_hit   (bp_hit),
    .bp_index (bp_index)
  );

endmodule

/* hw/breakpoint_unit.sv */
module breakpoint_unit #(
  parameter int NUM_BREAKPOINTS = 8
) (
  input  logic                               clk,
  input  logic                               rst,
  cmd_if.sink                                cmd_bus,
  input  dbg_pkg::addr_t                     bus_addr,
  input  logic                               bus_rd,
  output logic                               bp_hit,
  output logic [$clog2(NUM_BREAKPOINTS)-1:0] bp_index
);
  import dbg_pkg::*;

  localparam int IDX_W = $clog2(NUM_BREAKPOINTS);

  addr_t                      bp_addr [NUM_BREAKPOINTS];
  logic [NUM_BREAKPOINTS-1:0] bp_active;
  logic                       bp_enable;   // global on/off
  byte_t                      slot;
  logic                       rd_s;        // bus inputs, first stage
  logic                       rd_s_d;
  addr_t                      addr_s;
  logic                       rise_q;      // registered rd edge
  addr_t                      addr_q;
  logic [NUM_BREAKPOINTS-1:0] match;
  logic                       match_any;
  logic [IDX_W-1:0]           match_idx;

  assign slot = cmd_bus.params[0]; // out-of-range slots match no entry

  always_ff @(posedge clk) begin
    if (rst) begin
      bp_active <= '0;
      bp_enable <= 1'b0;
    end else if (cmd_bus.action) begin
      case (cmd_bus.cmd)
        set_breakpoint: begin
          for (int i = 0; i < NUM_BREAKPOINTS; i++) begin
            if (slot == i) bp_active[i] <= 1'b1;
          end
        end
        clear_breakpoint: begin
          for (int i = 0; i < NUM_BREAKPOINTS; i++) begin
            if (slot == i) bp_active[i] <= 1'b0;
          end
        end
        enable_breakpoints:  bp_enable <= 1'b1;
        disable_breakpoints: bp_enable <= 1'b0;
        default: ;
      endcase
    end
  end

  // slot address, high byte in params 2
  always_ff @(posedge clk) begin
    if (cmd_bus.action && cmd_bus.cmd == set_breakpoint) begin
      for (int i = 0; i < NUM_BREAKPOINTS; i++) begin
        if (slot == i) bp_addr[i] <= {cmd_bus.params[2], cmd_bus.params[1]};
      end
    end
  end

  // sample, detect edge, then decide hit
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_s   <= 1'b0;
      rd_s_d <= 1'b0;
      rise_q <= 1'b0;
    end else begin
      rd_s   <= bus_rd;
      rd_s_d <= rd_s;
      rise_q <= rd_s & ~rd_s_d; // one clk per read, even if held
    end
  end

  always_ff @(posedge clk) begin
    addr_s <= bus_addr;
    addr_q <= addr_s; // aligned with rise_q
  end

  // parallel compare, lowest slot wins
  always_comb begin
    match_any = 1'b0;
    match_idx = '0;
    for (int i = 0; i < NUM_BREAKPOINTS; i++) begin
      match[i] = bp_active[i] && (bp_addr[i] == addr_q);
    end
    for (int i = NUM_BREAKPOINTS - 1; i >= 0; i--) begin
      if (match[i]) begin
        match_any = 1'b1;
        match_idx = IDX_W'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      bp_hit   <= 1'b0;
      bp_index <= '0;
    end else begin
      bp_hit <= rise_q && bp_enable && match_any;
      if (rise_q && match_any) begin
        bp_index <= match_idx; // kept until the next hit
      end
    end
  end

endmodule

/* hw/host_ram.sv */
module host_ram #(
  parameter int RAM_ADDR_W = 10
) (
  input  logic           clk,
  input  logic           rst,
  cmd_if.sink            cmd_bus,
  output dbg_pkg::byte_t rd_data,
  output logic           rd_valid
);
  import dbg_pkg::*;

  localparam int DEPTH = 2 ** RAM_ADDR_W;

  byte_t                 mem [DEPTH];
  logic [15:0]           host_addr;  // little endian, params 1 and 0
  logic [RAM_ADDR_W-1:0] ram_addr;
  logic                  wr_en;
  logic                  rd_en;
  byte_t                 rd_q;       // array output register
  logic                  rd_pipe;

  assign host_addr = {cmd_bus.params[1], cmd_bus.params[0]};
  assign ram_addr  = host_addr[RAM_ADDR_W-1:0]; // upper bits dropped
  assign wr_en     = cmd_bus.action && (cmd_bus.cmd == bram_poke);
  assign rd_en     = cmd_bus.action && (cmd_bus.cmd == bram_peek);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[ram_addr] <= cmd_bus.params[2];
    end
    if (rd_en) begin
      rd_q <= mem[ram_addr];
    end
    if (rd_pipe) begin
      rd_data <= rd_q; // second stage
    end
  end

  // valid follows the data two clk behind the action
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_pipe  <= 1'b0;
      rd_valid <= 1'b0;
    end else begin
      rd_pipe  <= rd_en;
      rd_valid <= rd_pipe;
    end
  end

endmodule

/* hw/cmd_parser.sv */
module cmd_parser (
  input  logic           clk,
  input  logic           rst,
  input  dbg_pkg::byte_t rx_byte,
  input  logic           rx_strobe,
  input  logic           cs_active,
  input  logic           reply_busy,
  input  dbg_pkg::byte_t rd_data,
  input  logic           rd_valid,
  output logic           accept_rx,
  output dbg_pkg::byte_t reply_byte,
  output logic           reply_bits_load,
  cmd_if.parser          cmd_bus
);
  import dbg_pkg::*;

  localparam int CNT_W = $clog2(PARAM_COUNT + 1);
  localparam int IDX_W = $clog2(PARAM_COUNT);

  typedef enum logic {
    st_idle,
    st_read_params
  } state_t;

  state_t           state;
  logic [CNT_W-1:0] remaining;  // parameter bytes still to come
  logic [IDX_W-1:0] idx;        // next params slot
  logic [CNT_W-1:0] n_params;
  logic             known;
  logic             cmd_start;  // code byte of a supported command
  logic             param_take;
  logic             instant_reply;

  // parameter count per code, unknown codes fall through
  always_comb begin
    known    = 1'b1;
    n_params = '0;
    case (rx_byte)
      get_cookie, get_version,
      enable_breakpoints, disable_breakpoints: n_params = CNT_W'(0);
      bram_poke, set_breakpoint:               n_params = CNT_W'(3);
      bram_peek:                               n_params = CNT_W'(2);
      clear_breakpoint:                        n_params = CNT_W'(1);
      default:                                 known    = 1'b0;
    endcase
  end

  assign cmd_start     = cs_active && rx_strobe && (state == st_idle) && known;
  assign param_take    = cs_active && rx_strobe && (state == st_read_params);
  assign instant_reply = (rx_byte == get_cookie) || (rx_byte == get_version);

  // hold off new bytes while a reply is still going out
  assign accept_rx = !((state == st_idle) && reply_busy);

  always_ff @(posedge clk) begin
    if (rst) begin
      state           <= st_idle;
      remaining       <= '0;
      idx             <= '0;
      cmd_bus.action  <= 1'b0;
      reply_bits_load <= 1'b0;
    end else begin
      cmd_bus.action  <= 1'b0;
      reply_bits_load <= rd_valid; // peek data is back
      if (!cs_active) begin
        state <= st_idle; // aborted message
      end else if (cmd_start) begin
        idx       <= '0;
        remaining <= n_params;
        if (n_params == '0) begin
          cmd_bus.action  <= 1'b1;
          reply_bits_load <= instant_reply;
        end else begin
          state <= st_read_params;
        end
      end else if (param_take) begin
        idx       <= idx + IDX_W'(1);
        remaining <= remaining - CNT_W'(1);
        if (remaining == CNT_W'(1)) begin
          cmd_bus.action <= 1'b1; // last parameter in
          state          <= st_idle;
        end
      end
    end
  end

  // command, parameters and reply byte
  always_ff @(posedge clk) begin
    if (cmd_start) begin
      cmd_bus.cmd <= cmd_code_t'(rx_byte);
    end
    if (param_take) begin
      cmd_bus.params[idx] <= rx_byte;
    end
    if (cmd_start && rx_byte == get_cookie) begin
      reply_byte <= COOKIE;
    end else if (cmd_start && rx_byte == get_version) begin
      reply_byte <= VERSION_BYTE;
    end else if (rd_valid) begin
      reply_byte <= rd_data;
    end
  end

endmodule

/* hw/spi_byte_link.sv */
module spi_byte_link (
  input  logic           clk,
  input  logic           rst,
  input  logic           spi_cs_n,
  input  logic           spi_sck,
  input  logic           spi_mosi,
  input  dbg_pkg::byte_t reply_byte,
  input  logic           reply_bits_load,
  input  logic           accept_rx,
  output logic           spi_miso,
  output dbg_pkg::byte_t rx_byte,
  output logic           rx_strobe,
  output logic           cs_active,
  output logic           reply_busy
);
  import dbg_pkg::*;

  logic [2:0] sck_sync;  // two sync flops plus one for edge detect
  logic [1:0] cs_sync;
  logic [1:0] mosi_sync;
  logic       sck_rise;
  logic       sck_fall;
  logic [2:0] bit_cnt;   // rx bit position within the byte
  logic [3:0] tx_left;   // falling edges left for the reply, 9 down to 0
  byte_t      tx_shift;

  assign sck_rise  = (sck_sync[2:1] == 2'b01);
  assign sck_fall  = (sck_sync[2:1] == 2'b10);
  assign cs_active = ~cs_sync[1];

  always_ff @(posedge clk) begin
    if (rst) begin
      sck_sync <= '0;
      cs_sync  <= '1; // idle as deselected
    end else begin
      sck_sync <= {sck_sync[1:0], spi_sck};
      cs_sync  <= {cs_sync[0], spi_cs_n};
    end
  end

  always_ff @(posedge clk) begin
    mosi_sync <= {mosi_sync[0], spi_mosi};
    if (cs_active && sck_rise) begin
      rx_byte <= {rx_byte[6:0], mosi_sync[1]}; // msb first
    end
  end

  // bit counter, restarts whenever cs drops out
  always_ff @(posedge clk) begin
    if (rst || !cs_active) begin
      bit_cnt   <= '0;
      rx_strobe <= 1'b0;
    end else begin
      rx_strobe <= sck_rise && accept_rx && (bit_cnt == 3'd7);
      if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
      end
    end
  end

  // reply shifter
  // first counted falling edge is the tail of the request byte,
  // second one loads the reply, the remaining seven shift it out
  always_ff @(posedge clk) begin
    if (rst || !cs_active) begin
      tx_left <= '0; // pending reply dropped on cs release
    end else if (reply_bits_load) begin
      tx_left <= 4'd9;
    end else if (sck_fall && tx_left != '0) begin
      tx_left <= tx_left - 4'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      tx_shift <= '0;
    end else if (cs_active && sck_fall && tx_left != '0) begin
      if (tx_left == 4'd8) begin
        tx_shift <= reply_byte;
      end else begin
        tx_shift <= {tx_shift[6:0], 1'b0};
      end
    end
  end

  assign reply_busy = (tx_left != '0);
  assign spi_miso   = cs_active & tx_shift[7]; // low while deselected

endmodule

/* hw/cmd_if.sv */
// completed command from the parser to the sinks
interface cmd_if;
  import dbg_pkg::*;

  logic      action;               // one clk per completed command
  cmd_code_t cmd;                  // held until the next command byte
  byte_t     params [PARAM_COUNT]; // params[0] is the first byte after the code

  // parser side
  modport parser (
    output action,
    output cmd,
    output params
  );

  // ram and breakpoint side, each decodes its own codes
  modport sink (
    input action,
    input cmd,
    input params
  );

endinterface

/* hw/dbg_pkg.sv */
package dbg_pkg;

  typedef logic [7:0]  byte_t;  // one spi byte
  typedef logic [15:0] addr_t;  // external bus address

  // command codes as sent by the host
  // gaps in the numbering belong to commands this link does not serve
  typedef enum logic [7:0] {
    get_cookie          = 8'd0,
    bram_poke           = 8'd1,
    bram_peek           = 8'd2,
    set_breakpoint      = 8'd6,
    clear_breakpoint    = 8'd7,
    enable_breakpoints  = 8'd11,
    disable_breakpoints = 8'd12,
    get_version         = 8'd15
  } cmd_code_t;

  // longest parameter list (poke and set_breakpoint)
  localparam int PARAM_COUNT = 3;

  // fixed reply so the host can tell the fpga is alive
  localparam byte_t COOKIE = 8'haf;

  // version reply layout is major in [7:5], minor in [4:0]
  localparam logic [2:0] VERSION_MAJOR = 3'd0;
  localparam logic [4:0] VERSION_MINOR = 5'd3;
  localparam byte_t      VERSION_BYTE  = {VERSION_MAJOR, VERSION_MINOR};

endpackage
